//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= src.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@status=0; ./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned INSTR_WIDTH    = 32;
    localparam int unsigned REG_ADDR_WIDTH = 5;
    localparam int unsigned NR_REGS        = 32;
    localparam int unsigned INSTRET_WIDTH  = 16;

    // ------------------------------
    // Instruction encodings
    // ------------------------------
    // Major opcodes for the register-register and register-immediate forms
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // Minor operation codes shared by both opcodes
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // Only meaningful together with FUNCT3_ADD_SUB on OPCODE_OP
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    // ------------------------------
    // ALU operations
    // ------------------------------
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

endpackage

`default_nettype wire

//--- execute/alu.sv
`default_nettype none

module alu #(
    parameter int unsigned XLEN = 32
) (
    input  core_pkg::alu_op_t op_i,
    input  logic [XLEN-1:0]   a_i,
    input  logic [XLEN-1:0]   b_i,
    output logic [XLEN-1:0]   result_o
);
    import core_pkg::*;

    logic less_than;

    // Signed compare for SLT and SLTI
    assign less_than = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, less_than};
            // Two encodings of the 3-bit type are unused
            default: result_o = a_i + b_i;
        endcase
    end

endmodule

`default_nettype wire

//--- execute/ex_stage.sv
`default_nettype none

module ex_stage #(
    parameter int unsigned XLEN = 32
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                dec_valid_i,
    input  core_pkg::alu_op_t                   dec_op_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] dec_rd_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] dec_rs1_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] dec_rs2_i,
    input  logic                                dec_use_imm_i,
    input  logic [XLEN-1:0]                     dec_imm_i,
    input  logic [XLEN-1:0]                     dec_rs1_data_i,
    input  logic [XLEN-1:0]                     dec_rs2_data_i,
    input  logic                                dec_illegal_i,
    input  logic                                wb_en_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [XLEN-1:0]                     wb_data_i,
    output logic                                ex_valid_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] ex_rd_o,
    output logic [XLEN-1:0]                     ex_result_o,
    output logic                                ex_illegal_o
);

    logic            ex_fwd_ok;
    logic            ex_hit_a;
    logic            ex_hit_b;
    logic            wb_hit_a;
    logic            wb_hit_b;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;

    // ------------------------------
    // Operand bypass
    // ------------------------------
    // Previous result may forward only if it will really be written
    assign ex_fwd_ok = ex_valid_o && !ex_illegal_o && (ex_rd_o != '0);

    assign ex_hit_a = ex_fwd_ok && (dec_rs1_i == ex_rd_o);
    assign ex_hit_b = ex_fwd_ok && (dec_rs2_i == ex_rd_o);
    assign wb_hit_a = wb_en_i && (dec_rs1_i == wb_addr_i);
    assign wb_hit_b = wb_en_i && (dec_rs2_i == wb_addr_i);

    // Execute result is newer than the one in commit
    assign operand_a = ex_hit_a ? ex_result_o :
                       wb_hit_a ? wb_data_i   : dec_rs1_data_i;
    assign rs2_value = ex_hit_b ? ex_result_o :
                       wb_hit_b ? wb_data_i   : dec_rs2_data_i;
    assign operand_b = dec_use_imm_i ? dec_imm_i : rs2_value;

    alu #(
        .XLEN ( XLEN )
    ) i_alu (
        .op_i     ( dec_op_i   ),
        .a_i      ( operand_a  ),
        .b_i      ( operand_b  ),
        .result_o ( alu_result )
    );

    // ------------------------------
    // Execute pipeline register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_valid_o   <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o   <= dec_valid_i;
            ex_illegal_o <= dec_valid_i & dec_illegal_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            ex_rd_o     <= dec_rd_i;
            ex_result_o <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- source/commit_stage.sv
`default_nettype none

module commit_stage #(
    parameter int unsigned XLEN = 32
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                ex_valid_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] ex_rd_i,
    input  logic [XLEN-1:0]                     ex_result_i,
    input  logic                                ex_illegal_i,
    output logic                                wb_en_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [XLEN-1:0]                     wb_data_o,
    output logic                                commit_valid_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] commit_rd_o,
    output logic [XLEN-1:0]                     commit_data_o,
    output logic                                commit_illegal_o,
    output logic [core_pkg::INSTRET_WIDTH-1:0]  instret_o
);
    import core_pkg::*;

    // ------------------------------
    // Commit register and retire counter
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_o   <= 1'b0;
            commit_illegal_o <= 1'b0;
            commit_rd_o      <= '0;
            commit_data_o    <= '0;
            instret_o        <= '0;
        end else begin
            commit_valid_o   <= ex_valid_i;
            commit_illegal_o <= ex_valid_i & ex_illegal_i;
            if (ex_valid_i) begin
                commit_rd_o   <= ex_rd_i;
                commit_data_o <= ex_result_i;
            end
            // Wraps silently at the counter width
            if (ex_valid_i && !ex_illegal_i) begin
                instret_o <= instret_o + INSTRET_WIDTH'(1);
            end
        end
    end

    // Register file takes this write at the next edge
    assign wb_en_o   = commit_valid_o && !commit_illegal_o && (commit_rd_o != '0);
    assign wb_addr_o = commit_rd_o;
    assign wb_data_o = commit_data_o;

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter int unsigned XLEN = 32
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                instr_valid_i,
    input  logic [core_pkg::INSTR_WIDTH-1:0]    instr_i,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] rf_raddr_a_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] rf_raddr_b_o,
    input  logic [XLEN-1:0]                     rf_rdata_a_i,
    input  logic [XLEN-1:0]                     rf_rdata_b_i,
    output logic                                dec_valid_o,
    output core_pkg::alu_op_t                   dec_op_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] dec_rd_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] dec_rs1_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] dec_rs2_o,
    output logic                                dec_use_imm_o,
    output logic [XLEN-1:0]                     dec_imm_o,
    output logic [XLEN-1:0]                     dec_rs1_data_o,
    output logic [XLEN-1:0]                     dec_rs2_data_o,
    output logic                                dec_illegal_o
);
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            funct3_ok;
    alu_op_t         op_d;
    logic            use_imm_d;
    logic            illegal_d;
    logic [XLEN-1:0] imm_d;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Register file is read in the same cycle the instruction arrives
    assign rf_raddr_a_o = instr_i[19:15];
    assign rf_raddr_b_o = instr_i[24:20];

    // Sign-extended I-type immediate
    assign imm_d = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        op_d      = ALU_ADD;
        funct3_ok = 1'b1;
        case (funct3)
            FUNCT3_ADD_SUB: op_d = ALU_ADD;
            FUNCT3_SLT:     op_d = ALU_SLT;
            FUNCT3_XOR:     op_d = ALU_XOR;
            FUNCT3_OR:      op_d = ALU_OR;
            FUNCT3_AND:     op_d = ALU_AND;
            default:        funct3_ok = 1'b0;
        endcase

        use_imm_d = (opcode == OPCODE_OP_IMM);
        illegal_d = !funct3_ok;

        // funct7 only qualifies the register-register form
        if (opcode == OPCODE_OP) begin
            if (funct3 == FUNCT3_ADD_SUB && funct7 == FUNCT7_SUB) begin
                op_d = ALU_SUB;
            end else if (funct7 != 7'b0) begin
                illegal_d = 1'b1;
            end
        end else if (opcode != OPCODE_OP_IMM) begin
            illegal_d = 1'b1;
        end
    end

    // ------------------------------
    // Decode pipeline register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_valid_o   <= 1'b0;
            dec_illegal_o <= 1'b0;
        end else begin
            dec_valid_o   <= instr_valid_i;
            dec_illegal_o <= instr_valid_i & illegal_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            dec_op_o       <= op_d;
            dec_rd_o       <= instr_i[11:7];
            dec_rs1_o      <= rf_raddr_a_o;
            dec_rs2_o      <= rf_raddr_b_o;
            dec_use_imm_o  <= use_imm_d;
            dec_imm_o      <= imm_d;
            dec_rs1_data_o <= rf_rdata_a_i;
            dec_rs2_data_o <= rf_rdata_b_i;
        end
    end

endmodule

`default_nettype wire

//--- source/regfile.sv
`default_nettype none

module regfile #(
    parameter int unsigned XLEN = 32
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] raddr_a_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] raddr_b_i,
    output logic [XLEN-1:0]                     rdata_a_o,
    output logic [XLEN-1:0]                     rdata_b_o,
    input  logic                                we_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [XLEN-1:0]                     wdata_i
);
    import core_pkg::*;

    logic [XLEN-1:0] regs_q [NR_REGS];
    logic            we_valid;

    // x0 is never written, so it keeps its reset value of zero
    assign we_valid = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_valid) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Write-through so a value retiring this cycle is already visible
    assign rdata_a_o = (we_valid && waddr_i == raddr_a_i) ? wdata_i : regs_q[raddr_a_i];
    assign rdata_b_o = (we_valid && waddr_i == raddr_b_i) ? wdata_i : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- source/rv_core.sv
`default_nettype none

module rv_core #(
    parameter int unsigned XLEN = 32
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                instr_valid_i,
    input  logic [core_pkg::INSTR_WIDTH-1:0]    instr_i,
    output logic                                commit_valid_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] commit_rd_o,
    output logic [XLEN-1:0]                     commit_data_o,
    output logic                                commit_illegal_o,
    output logic [core_pkg::INSTRET_WIDTH-1:0]  instret_o
);
    import core_pkg::*;

    // ------------------------------
    // Decode <-> regfile
    // ------------------------------
    logic [REG_ADDR_WIDTH-1:0] rf_raddr_a;
    logic [REG_ADDR_WIDTH-1:0] rf_raddr_b;
    logic [XLEN-1:0]           rf_rdata_a;
    logic [XLEN-1:0]           rf_rdata_b;

    // ------------------------------
    // Decode -> execute
    // ------------------------------
    logic                      dec_valid;
    alu_op_t                   dec_op;
    logic [REG_ADDR_WIDTH-1:0] dec_rd;
    logic [REG_ADDR_WIDTH-1:0] dec_rs1;
    logic [REG_ADDR_WIDTH-1:0] dec_rs2;
    logic                      dec_use_imm;
    logic [XLEN-1:0]           dec_imm;
    logic [XLEN-1:0]           dec_rs1_data;
    logic [XLEN-1:0]           dec_rs2_data;
    logic                      dec_illegal;

    // ------------------------------
    // Execute -> commit
    // ------------------------------
    logic                      ex_valid;
    logic [REG_ADDR_WIDTH-1:0] ex_rd;
    logic [XLEN-1:0]           ex_result;
    logic                      ex_illegal;

    // Write-back port that also feeds the bypass
    logic                      wb_en;
    logic [REG_ADDR_WIDTH-1:0] wb_addr;
    logic [XLEN-1:0]           wb_data;

    decode_stage #(
        .XLEN ( XLEN )
    ) i_decode_stage (
        .clk_i          ( clk_i         ),
        .rst_ni         ( rst_ni        ),
        .instr_valid_i  ( instr_valid_i ),
        .instr_i        ( instr_i       ),
        .rf_raddr_a_o   ( rf_raddr_a    ),
        .rf_raddr_b_o   ( rf_raddr_b    ),
        .rf_rdata_a_i   ( rf_rdata_a    ),
        .rf_rdata_b_i   ( rf_rdata_b    ),
        .dec_valid_o    ( dec_valid     ),
        .dec_op_o       ( dec_op        ),
        .dec_rd_o       ( dec_rd        ),
        .dec_rs1_o      ( dec_rs1       ),
        .dec_rs2_o      ( dec_rs2       ),
        .dec_use_imm_o  ( dec_use_imm   ),
        .dec_imm_o      ( dec_imm       ),
        .dec_rs1_data_o ( dec_rs1_data  ),
        .dec_rs2_data_o ( dec_rs2_data  ),
        .dec_illegal_o  ( dec_illegal   )
    );

    regfile #(
        .XLEN ( XLEN )
    ) i_regfile (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .raddr_a_i ( rf_raddr_a ),
        .raddr_b_i ( rf_raddr_b ),
        .rdata_a_o ( rf_rdata_a ),
        .rdata_b_o ( rf_rdata_b ),
        .we_i      ( wb_en      ),
        .waddr_i   ( wb_addr    ),
        .wdata_i   ( wb_data    )
    );

    ex_stage #(
        .XLEN ( XLEN )
    ) i_ex_stage (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .dec_valid_i    ( dec_valid    ),
        .dec_op_i       ( dec_op       ),
        .dec_rd_i       ( dec_rd       ),
        .dec_rs1_i      ( dec_rs1      ),
        .dec_rs2_i      ( dec_rs2      ),
        .dec_use_imm_i  ( dec_use_imm  ),
        .dec_imm_i      ( dec_imm      ),
        .dec_rs1_data_i ( dec_rs1_data ),
        .dec_rs2_data_i ( dec_rs2_data ),
        .dec_illegal_i  ( dec_illegal  ),
        .wb_en_i        ( wb_en        ),
        .wb_addr_i      ( wb_addr      ),
        .wb_data_i      ( wb_data      ),
        .ex_valid_o     ( ex_valid     ),
        .ex_rd_o        ( ex_rd        ),
        .ex_result_o    ( ex_result    ),
        .ex_illegal_o   ( ex_illegal   )
    );

    commit_stage #(
        .XLEN ( XLEN )
    ) i_commit_stage (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .ex_valid_i       ( ex_valid         ),
        .ex_rd_i          ( ex_rd            ),
        .ex_result_i      ( ex_result        ),
        .ex_illegal_i     ( ex_illegal       ),
        .wb_en_o          ( wb_en            ),
        .wb_addr_o        ( wb_addr          ),
        .wb_data_o        ( wb_data          ),
        .commit_valid_o   ( commit_valid_o   ),
        .commit_rd_o      ( commit_rd_o      ),
        .commit_data_o    ( commit_data_o    ),
        .commit_illegal_o ( commit_illegal_o ),
        .instret_o        ( instret_o        )
    );

endmodule

`default_nettype wire

//--- src.f
common/core_pkg.sv
execute/alu.sv
execute/ex_stage.sv
source/regfile.sv
source/decode_stage.sv
source/commit_stage.sv
source/rv_core.sv
verif/rv_core_assertions.sv
verif/tb_rv_core.sv

//--- verif/rv_core_assertions.sv
`default_nettype none

module rv_core_assertions (
    input logic                               clk_i,
    input logic                               rst_ni,
    input logic                               commit_valid_i,
    input logic                               commit_illegal_i,
    input logic [core_pkg::INSTRET_WIDTH-1:0] instret_i
);

    // ------------------------------
    // Commit port rules
    // ------------------------------
    a_illegal_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_illegal_i |-> commit_valid_i)
        else $error("commit_illegal_o is high while commit_valid_o is low");

    a_commit_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$isunknown({commit_valid_i, commit_illegal_i}))
        else $error("commit_valid_o or commit_illegal_o is unknown");

    // Counter only moves with a legal retirement at the same edge
    a_instret_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (instret_i != $past(instret_i)) |-> (commit_valid_i && !commit_illegal_i))
        else $error("instret_o changed without a legal commit");

endmodule

bind rv_core rv_core_assertions i_rv_core_assertions (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .commit_valid_i   ( commit_valid_o   ),
    .commit_illegal_i ( commit_illegal_o ),
    .instret_i        ( instret_o        )
);

`default_nettype wire

//--- verif/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
    import core_pkg::*;

    localparam int unsigned XLEN          = 32;
    localparam int unsigned LATENCY       = 3;
    // Long enough for instret to wrap at least once
    localparam int unsigned NUM_CYCLES    = 100000;
    localparam int unsigned IDLE_CHECKS   = 8;
    localparam int unsigned DRAIN_TIMEOUT = 20;

    logic                      clk_i = 1'b0;
    logic                      rst_ni;
    logic                      instr_valid_i;
    logic [INSTR_WIDTH-1:0]    instr_i;
    logic                      commit_valid_o;
    logic [REG_ADDR_WIDTH-1:0] commit_rd_o;
    logic [XLEN-1:0]           commit_data_o;
    logic                      commit_illegal_o;
    logic [INSTRET_WIDTH-1:0]  instret_o;

    // Reference model state
    logic [XLEN-1:0]           model_regs [NR_REGS];
    logic [REG_ADDR_WIDTH-1:0] exp_rd_q [$];
    logic [XLEN-1:0]           exp_data_q [$];
    logic                      exp_illegal_q [$];
    int unsigned               exp_due_q [$];
    int unsigned               cycle_cnt = 0;
    int unsigned               legal_cnt;
    integer                    seed;

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    rv_core #(
        .XLEN ( XLEN )
    ) i_rv_core (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .instr_valid_i    ( instr_valid_i    ),
        .instr_i          ( instr_i          ),
        .commit_valid_o   ( commit_valid_o   ),
        .commit_rd_o      ( commit_rd_o      ),
        .commit_data_o    ( commit_data_o    ),
        .commit_illegal_o ( commit_illegal_o ),
        .instret_o        ( instret_o        )
    );

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    // Kinds 0..5 are ADD SUB AND OR XOR SLT, 6..10 are ADDI ANDI ORI XORI SLTI
    function automatic logic [INSTR_WIDTH-1:0] encode_instr(
        input int unsigned               kind,
        input logic [REG_ADDR_WIDTH-1:0] rd,
        input logic [REG_ADDR_WIDTH-1:0] rs1,
        input logic [REG_ADDR_WIDTH-1:0] rs2,
        input logic [11:0]               imm
    );
        logic [2:0] funct3;
        logic [6:0] funct7;

        case (kind)
            0, 1, 6: funct3 = FUNCT3_ADD_SUB;
            2, 7:    funct3 = FUNCT3_AND;
            3, 8:    funct3 = FUNCT3_OR;
            4, 9:    funct3 = FUNCT3_XOR;
            default: funct3 = FUNCT3_SLT;
        endcase
        funct7 = (kind == 1) ? FUNCT7_SUB : 7'b0;
        if (kind < 6) begin
            return {funct7, rs2, rs1, funct3, rd, OPCODE_OP};
        end else begin
            return {imm, rs1, funct3, rd, OPCODE_OP_IMM};
        end
    endfunction

    function automatic logic [XLEN-1:0] model_alu(input int unsigned kind,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [XLEN-1:0] result;

        case (kind)
            0, 6:    result = a + b;
            1:       result = a - b;
            2, 7:    result = a & b;
            3, 8:    result = a | b;
            4, 9:    result = a ^ b;
            default: result = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
        endcase
        return result;
    endfunction

    // Drives one instruction and records its expected commit
    task automatic send_random_instr();
        logic [31:0]               fields;
        logic [31:0]               pick;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [11:0]               imm;
        logic [6:0]                opcode;
        logic [XLEN-1:0]           op_b;
        logic [XLEN-1:0]           result;
        int unsigned               kind;

        fields = $random(seed);
        pick   = $random(seed);
        // Only x0..x7 so dependencies come up often
        rd     = {2'b00, fields[2:0]};
        rs1    = {2'b00, fields[5:3]};
        rs2    = {2'b00, fields[8:6]};
        imm    = fields[20:9];

        if (fields[24:21] == 4'd0) begin
            opcode = pick[6:0];
            if (opcode == OPCODE_OP || opcode == OPCODE_OP_IMM) begin
                opcode[6] = ~opcode[6];
            end
            instr_valid_i <= 1'b1;
            instr_i       <= {pick[31:7], opcode};
            exp_rd_q.push_back(rd);
            exp_data_q.push_back('0);
            exp_illegal_q.push_back(1'b1);
        end else begin
            kind = pick % 32'd11;
            if (kind >= 6) begin
                op_b = {{(XLEN-12){imm[11]}}, imm};
            end else begin
                op_b = model_regs[rs2];
            end
            result = model_alu(kind, model_regs[rs1], op_b);
            instr_valid_i <= 1'b1;
            instr_i       <= encode_instr(kind, rd, rs1, rs2, imm);
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(result);
            exp_illegal_q.push_back(1'b0);
            if (rd != '0) begin
                model_regs[rd] = result;
            end
        end
        // Sampled at the next edge, then three edges of latency
        exp_due_q.push_back(cycle_cnt + 1 + LATENCY);
    endtask

    // Called at the falling edge, where commit outputs are stable
    task automatic monitor_commit();
        if (commit_valid_o) begin
            if (exp_due_q.size() == 0) begin
                report_failure("a commit appeared with no instruction outstanding");
            end else begin
                compare_value("commit_cycle", 64'(exp_due_q[0]), 64'(cycle_cnt));
                compare_value("commit_illegal", 64'(exp_illegal_q[0]), 64'(commit_illegal_o));
                if (!exp_illegal_q[0]) begin
                    compare_value("commit_rd", 64'(exp_rd_q[0]), 64'(commit_rd_o));
                    compare_value("commit_data", 64'(exp_data_q[0]), 64'(commit_data_o));
                    legal_cnt++;
                end
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_illegal_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_cnt) begin
            report_failure("an expected commit did not appear in its cycle");
        end
        compare_value("instret", 64'(INSTRET_WIDTH'(legal_cnt)), 64'(instret_o));
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [31:0] rnd;
        int unsigned wait_cnt;

        seed          = 32'hc39c;
        rst_ni        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        legal_cnt     = 0;
        for (int i = 0; i < NR_REGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Quiet pipeline right after reset
        repeat (IDLE_CHECKS) begin
            @(negedge clk_i);
            compare_value("idle_commit_valid", 64'd0, 64'(commit_valid_o));
            compare_value("idle_commit_illegal", 64'd0, 64'(commit_illegal_o));
            compare_value("idle_instret", 64'd0, 64'(instret_o));
        end

        for (int unsigned cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk_i);
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) begin
                instr_valid_i <= 1'b0;
                instr_i       <= rnd;
            end else begin
                send_random_instr();
            end
            @(negedge clk_i);
            monitor_commit();
        end

        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        instr_i       <= '0;

        wait_cnt = 0;
        while (exp_due_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            monitor_commit();
            wait_cnt++;
        end

        if (exp_due_q.size() != 0) begin
            report_failure("the pipeline did not drain before the timeout");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
